//--- Bender.yml
package:
  name: pong

sources:
  - pong_pkg.sv
  - scan_if.sv
  - obj_if.sv
  - scan_timing.sv
  - quad_decoder.sv
  - object_state.sv
  - pixel_renderer.sv
  - pong_top.sv
  - target: test
    files:
      - tb_pong.sv

//--- flist.f
pong_pkg.sv
scan_if.sv
obj_if.sv
scan_timing.sv
quad_decoder.sv
object_state.sv
pixel_renderer.sv
pong_top.sv
tb_pong.sv

//--- obj_if.sv
`timescale 1ns/10ps

interface obj_if;

	// committed object positions, constant for a whole frame
	pong_pkg::coord_t pad_x;
	pong_pkg::coord_t ball_x;
	pong_pkg::coord_t ball_y;

	// current pixel is border or paddle
	logic solid;

	modport state (
		output pad_x,
		output ball_x,
		output ball_y,
		input solid
	);

	modport render (
		input pad_x,
		input ball_x,
		input ball_y,
		output solid
	);

endinterface

//--- object_state.sv
`timescale 1ns/10ps

module object_state (
	input logic clock,
	input logic reset,
	scan_if.sink scan,
	obj_if.state obj,
	input logic step,
	input logic dir
);

	// paddle position collected during the frame
	pong_pkg::coord_t pad_pending;

	// committed state seen by the renderer
	pong_pkg::coord_t pad_x_q;
	pong_pkg::coord_t ball_x_q;
	pong_pkg::coord_t ball_y_q;

	// 1 means +1 per frame, 0 means -1
	logic dx;
	logic dy;

	// probe pixels on the ball edges
	pong_pkg::coord_t probe_left;
	pong_pkg::coord_t probe_right;
	pong_pkg::coord_t probe_top;
	pong_pkg::coord_t probe_bottom;

	logic hit_left;
	logic hit_right;
	logic hit_top;
	logic hit_bottom;

	assign probe_left = ball_x_q - pong_pkg::BALL_HALF;
	assign probe_right = ball_x_q + pong_pkg::BALL_HALF;
	assign probe_top = ball_y_q - pong_pkg::BALL_HALF;
	assign probe_bottom = ball_y_q + pong_pkg::BALL_HALF;

	assign hit_left = obj.solid && (scan.px == probe_left) && (scan.py == ball_y_q);
	assign hit_right = obj.solid && (scan.px == probe_right) && (scan.py == ball_y_q);
	assign hit_top = obj.solid && (scan.px == ball_x_q) && (scan.py == probe_top);
	assign hit_bottom = obj.solid && (scan.px == ball_x_q) && (scan.py == probe_bottom);

	always_ff @(posedge clock) begin
		if (reset) begin
			pad_pending <= pong_pkg::PAD_X0;
			pad_x_q <= pong_pkg::PAD_X0;
			ball_x_q <= pong_pkg::BALL_X0;
			ball_y_q <= pong_pkg::BALL_Y0;
			dx <= 1'b1;
			dy <= 1'b1;
		end else begin
			// one pixel per encoder step, held at the limits
			if (step) begin
				if (dir && (pad_pending < pong_pkg::PAD_MAX)) begin
					pad_pending <= pad_pending + 1'b1;
				end else if (!dir && (pad_pending > pong_pkg::PAD_MIN)) begin
					pad_pending <= pad_pending - 1'b1;
				end
			end

			// bounce away from whatever the probe touched
			if (hit_left) begin
				dx <= 1'b1;
			end
			if (hit_right) begin
				dx <= 1'b0;
			end
			if (hit_top) begin
				dy <= 1'b1;
			end
			if (hit_bottom) begin
				dy <= 1'b0;
			end

			// new snapshot for the frame that starts now
			if (scan.frame_start) begin
				pad_x_q <= pad_pending;
				ball_x_q <= dx ? ball_x_q + 1'b1 : ball_x_q - 1'b1;
				ball_y_q <= dy ? ball_y_q + 1'b1 : ball_y_q - 1'b1;
			end
		end
	end

	assign obj.pad_x = pad_x_q;
	assign obj.ball_x = ball_x_q;
	assign obj.ball_y = ball_y_q;

	a_pad_in_range: assert property (
		@(posedge clock) disable iff (reset)
		(pad_x_q >= pong_pkg::PAD_MIN) && (pad_x_q <= pong_pkg::PAD_MAX)
	);

endmodule

//--- pixel_renderer.sv
`timescale 1ns/10ps

module pixel_renderer (
	input logic clock,
	input logic reset,
	scan_if.sink scan,
	obj_if.render obj,
	output logic vga_r,
	output logic vga_g,
	output logic vga_b,
	output logic vga_hsync,
	output logic vga_vsync,
	output pong_pkg::coord_t pix_x,
	output pong_pkg::coord_t pix_y
);

	logic visible;
	logic in_border;
	logic in_paddle;
	logic in_ball;
	logic in_checker;
	logic white;

	assign visible = (scan.px < pong_pkg::SCREEN_W) && (scan.py < pong_pkg::SCREEN_H);

	assign in_border = (scan.px < pong_pkg::BORDER) || (scan.px >= pong_pkg::BORDER_X_HI) ||
		(scan.py < pong_pkg::BORDER) || (scan.py >= pong_pkg::BORDER_Y_HI);

	// paddle bounds cannot wrap, pad_x is kept within 120..520
	assign in_paddle = (scan.px >= obj.pad_x - pong_pkg::PAD_HALF_W) &&
		(scan.px <= obj.pad_x + pong_pkg::PAD_HALF_W) &&
		(scan.py >= pong_pkg::PAD_Y - pong_pkg::PAD_HALF_H) &&
		(scan.py <= pong_pkg::PAD_Y + pong_pkg::PAD_HALF_H);

	assign in_ball = (scan.px >= obj.ball_x - pong_pkg::BALL_HALF) &&
		(scan.px <= obj.ball_x + pong_pkg::BALL_HALF) &&
		(scan.py >= obj.ball_y - pong_pkg::BALL_HALF) &&
		(scan.py <= obj.ball_y + pong_pkg::BALL_HALF);

	// 8x8 checker cells
	assign in_checker = scan.px[3] ^ scan.py[3];

	assign white = in_border | in_paddle | in_ball;

	// ball is not solid, it only bounces off walls and paddle
	assign obj.solid = visible && (in_border || in_paddle);

	always_ff @(posedge clock) begin
		if (reset) begin
			vga_r <= 1'b0;
			vga_g <= 1'b0;
			vga_b <= 1'b0;
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
		end else begin
			// red channel also carries the checker
			vga_r <= visible && (white || in_checker);
			vga_g <= visible && white;
			vga_b <= visible && white;
			vga_hsync <= scan.hsync;
			vga_vsync <= scan.vsync;
		end
	end

	// coordinates stay aligned with the colour they belong to
	always_ff @(posedge clock) begin
		pix_x <= scan.px;
		pix_y <= scan.py;
	end

endmodule

//--- pong_golden.txt
# encoder steps applied in this frame's blanking (negative is left)
# then paddle x, ball x and ball y shown in this frame
40 240 321 241
-300 280 322 242
25 120 323 243
450 145 324 244
-10 520 325 245
0 510 326 246

//--- pong_pkg.sv
package pong_pkg;

	// screen coordinate, wide enough for the full 800x525 scan
	typedef logic [9:0] coord_t;

	// visible area
	localparam coord_t SCREEN_W = 10'd640;
	localparam coord_t SCREEN_H = 10'd480;

	// border thickness, border covers x <= 7, x >= 633, y <= 7, y >= 473
	localparam coord_t BORDER = 10'd8;

	// paddle geometry, centre row is fixed
	localparam coord_t PAD_Y = 10'd400;
	localparam coord_t PAD_HALF_W = 10'd63;
	localparam coord_t PAD_HALF_H = 10'd3;

	// paddle centre travel limits
	localparam coord_t PAD_MIN = 10'd120;
	localparam coord_t PAD_MAX = 10'd520;

	// ball is a 15x15 square around its centre
	localparam coord_t BALL_HALF = 10'd7;

	// positions after reset
	localparam coord_t PAD_X0 = 10'd240;
	localparam coord_t BALL_X0 = 10'd320;
	localparam coord_t BALL_Y0 = 10'd240;

	// first border column and row on the right and bottom sides
	localparam coord_t BORDER_X_HI = SCREEN_W - BORDER + 10'd1;
	localparam coord_t BORDER_Y_HI = SCREEN_H - BORDER + 10'd1;

endpackage

//--- pong_top.sv
`timescale 1ns/10ps

module pong_top #(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_END = 751,
	parameter int V_TOTAL = 525,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_END = 491
) (
	input logic clock,
	input logic reset,
	input logic quad_a,
	input logic quad_b,
	output logic vga_r,
	output logic vga_g,
	output logic vga_b,
	output logic vga_hsync,
	output logic vga_vsync,
	output logic [9:0] pix_x,
	output logic [9:0] pix_y
);

	scan_if u_scan_if ();
	obj_if u_obj_if ();

	logic step;
	logic dir;

	scan_timing #(
		.H_TOTAL(H_TOTAL),
		.H_SYNC_START(H_SYNC_START),
		.H_SYNC_END(H_SYNC_END),
		.V_TOTAL(V_TOTAL),
		.V_SYNC_START(V_SYNC_START),
		.V_SYNC_END(V_SYNC_END)
	) u_scan_timing (
		.clock(clock),
		.reset(reset),
		.scan(u_scan_if.source)
	);

	quad_decoder u_quad_decoder (
		.clock(clock),
		.reset(reset),
		.quad_a(quad_a),
		.quad_b(quad_b),
		.step(step),
		.dir(dir)
	);

	object_state u_object_state (
		.clock(clock),
		.reset(reset),
		.scan(u_scan_if.sink),
		.obj(u_obj_if.state),
		.step(step),
		.dir(dir)
	);

	pixel_renderer u_pixel_renderer (
		.clock(clock),
		.reset(reset),
		.scan(u_scan_if.sink),
		.obj(u_obj_if.render),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.pix_x(pix_x),
		.pix_y(pix_y)
	);

endmodule

//--- quad_decoder.sv
`timescale 1ns/10ps

module quad_decoder (
	input logic clock,
	input logic reset,
	input logic quad_a,
	input logic quad_b,
	output logic step,
	output logic dir
);

	// two flop synchronizer per phase, bit 1 is the safe sample
	logic [1:0] a_sync;
	logic [1:0] b_sync;
	// previous synchronized sample
	logic a_prev;
	logic b_prev;
	logic a_changed;
	logic b_changed;

	always_ff @(posedge clock) begin
		a_sync <= {a_sync[0], quad_a};
		b_sync <= {b_sync[0], quad_b};
		a_prev <= a_sync[1];
		b_prev <= b_sync[1];
	end

	assign a_changed = a_sync[1] ^ a_prev;
	assign b_changed = b_sync[1] ^ b_prev;

	// any phase change is one step, direction from old a against new b
	always_ff @(posedge clock) begin
		if (reset) begin
			step <= 1'b0;
			dir <= 1'b0;
		end else begin
			step <= a_changed | b_changed;
			dir <= a_prev ^ b_sync[1];
		end
	end

	// gray code input, both phases flipping at once is a lost step
	a_no_double_edge: assert property (
		@(posedge clock) disable iff (reset)
		!(a_changed && b_changed)
	);

endmodule

//--- scan_if.sv
`timescale 1ns/10ps

interface scan_if;

	// current scan position
	pong_pkg::coord_t px;
	pong_pkg::coord_t py;

	// sync levels, active low
	logic hsync;
	logic vsync;

	// one cycle strobe at px == 0, py == 0
	logic frame_start;

	modport source (
		output px,
		output py,
		output hsync,
		output vsync,
		output frame_start
	);

	modport sink (
		input px,
		input py,
		input hsync,
		input vsync,
		input frame_start
	);

endinterface

//--- scan_timing.sv
`timescale 1ns/10ps

module scan_timing #(
	parameter int H_TOTAL = 800,
	parameter int H_SYNC_START = 656,
	parameter int H_SYNC_END = 751,
	parameter int V_TOTAL = 525,
	parameter int V_SYNC_START = 490,
	parameter int V_SYNC_END = 491
) (
	input logic clock,
	input logic reset,
	scan_if.source scan
);

	pong_pkg::coord_t px_q;
	pong_pkg::coord_t py_q;
	logic line_end;
	logic frame_end;

	assign line_end = (px_q == pong_pkg::coord_t'(H_TOTAL - 1));
	assign frame_end = (py_q == pong_pkg::coord_t'(V_TOTAL - 1));

	// pixel counter runs every cycle, line counter steps on the wrap
	always_ff @(posedge clock) begin
		if (reset) begin
			px_q <= '0;
			py_q <= '0;
		end else begin
			if (line_end) begin
				px_q <= '0;
				if (frame_end) begin
					py_q <= '0;
				end else begin
					py_q <= py_q + 1'b1;
				end
			end else begin
				px_q <= px_q + 1'b1;
			end
		end
	end

	assign scan.px = px_q;
	assign scan.py = py_q;

	// hsync window from x only, vsync window from y only
	assign scan.hsync = !((px_q >= pong_pkg::coord_t'(H_SYNC_START)) &&
		(px_q <= pong_pkg::coord_t'(H_SYNC_END)));
	assign scan.vsync = !((py_q >= pong_pkg::coord_t'(V_SYNC_START)) &&
		(py_q <= pong_pkg::coord_t'(V_SYNC_END)));

	assign scan.frame_start = (px_q == '0) && (py_q == '0);

	// counters never leave the frame
	a_scan_in_range: assert property (
		@(posedge clock) disable iff (reset)
		(px_q < pong_pkg::coord_t'(H_TOTAL)) && (py_q < pong_pkg::coord_t'(V_TOTAL))
	);

endmodule

//--- tb_pong.sv
`timescale 1ns/10ps

module tb_pong;

	localparam int H_TOTAL = 800;
	localparam int V_TOTAL = 525;
	localparam int MAX_FRAMES = 6;
	// six full frames plus a tenth for reset and slack
	localparam int TIMEOUT_CYCLES = MAX_FRAMES * H_TOTAL * V_TOTAL +
		(MAX_FRAMES * H_TOTAL * V_TOTAL) / 10;

	localparam int B_SYNC = 0;
	localparam int B_FRAME = 1;
	localparam int B_BALL = 2;
	localparam int B_PAD = 3;
	localparam int B_BLANK = 4;

	logic clock;
	logic reset;
	logic quad_a;
	logic quad_b;
	logic vga_r;
	logic vga_g;
	logic vga_b;
	logic vga_hsync;
	logic vga_vsync;
	logic [9:0] pix_x;
	logic [9:0] pix_y;

	string names [5] = '{"sync", "frame content", "ball motion", "paddle control", "blanking"};
	int checks [5];
	int errors [5];
	int steps_q [$];
	int pad_q [$];
	int bx_q [$];
	int by_q [$];
	// gray order for a move to the right, phase index walks it
	logic [1:0] gray_seq [4] = '{2'b00, 2'b01, 2'b11, 2'b10};
	int phase;
	int cycle_count;
	logic monitor_on;
	int got_pad;
	int got_bx;
	int got_by;
	int exp_x;
	int exp_y;
	int unsigned seed_init;

	pong_top u_dut (
		.clock(clock),
		.reset(reset),
		.quad_a(quad_a),
		.quad_b(quad_b),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync),
		.pix_x(pix_x),
		.pix_y(pix_y)
	);

	always begin
		#50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic compare_value(input int beh, input int got, input int exp, input string what);
		checks[beh]++;
		assert (got == exp) else begin
			errors[beh]++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// colour from the drawing rules, far border band starts at 633 and 473
	function automatic logic [2:0] expected_rgb(input int x, input int y, input int pad,
		input int bx, input int by);
		logic on_white;
		on_white = (x < 8) || (x >= 633) || (y < 8) || (y >= 473) ||
			((x >= pad - 63) && (x <= pad + 63) && (y >= 397) && (y <= 403)) ||
			((x >= bx - 7) && (x <= bx + 7) && (y >= by - 7) && (y <= by + 7));
		if (on_white) begin
			return 3'b111;
		end else if ((((x / 8) + (y / 8)) % 2) == 1) begin
			return 3'b100;
		end
		return 3'b000;
	endfunction

	// scan position, sync windows and black blanking, checked on every pixel
	always @(negedge clock) begin
		if (monitor_on) begin
			compare_value(B_SYNC, pix_x, exp_x, "pix_x");
			compare_value(B_SYNC, pix_y, exp_y, "pix_y");
			compare_value(B_SYNC, vga_hsync, !((pix_x >= 656) && (pix_x <= 751)), "hsync");
			compare_value(B_SYNC, vga_vsync, !((pix_y >= 490) && (pix_y <= 491)), "vsync");
			if ((pix_x >= 640) || (pix_y >= 480)) begin
				compare_value(B_BLANK, {vga_r, vga_g, vga_b}, 0, "blanking colour");
			end
			// position due on the next pixel
			if (exp_x == H_TOTAL - 1) begin
				exp_x = 0;
				exp_y = (exp_y == V_TOTAL - 1) ? 0 : exp_y + 1;
			end else begin
				exp_x = exp_x + 1;
			end
		end
	end

	task automatic read_golden();
		int fd;
		int n;
		int s;
		int p;
		int bx;
		int by;
		string line;
		fd = $fopen("pong_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open pong_golden.txt");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if ((line.len() > 0) && (line.getc(0) != "#")) begin
					n = $sscanf(line, "%d %d %d %d", s, p, bx, by);
					if (n == 4) begin
						steps_q.push_back(s);
						pad_q.push_back(p);
						bx_q.push_back(bx);
						by_q.push_back(by);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_steps(input int count);
		int n;
		int i;
		n = (count < 0) ? -count : count;
		for (i = 0; i < n; i++) begin
			phase = (count > 0) ? (phase + 1) % 4 : (phase + 3) % 4;
			@(posedge clock);
			#10;
			{quad_a, quad_b} = gray_seq[phase];
			repeat (7 + ($urandom % 8)) @(posedge clock);
		end
	endtask

	// walks the visible part of one frame and finds paddle and ball
	task automatic capture_frame(input int f);
		int x;
		int y;
		int pad_lo;
		int pad_hi;
		int bx_lo;
		int bx_hi;
		int by_lo;
		int by_hi;
		logic [2:0] rgb;
		logic [2:0] exp_rgb;
		pad_lo = 1000;
		pad_hi = -1;
		bx_lo = 1000;
		bx_hi = -1;
		by_lo = 1000;
		by_hi = -1;
		@(negedge clock);
		while (!((pix_x == 0) && (pix_y == 0))) begin
			@(negedge clock);
		end
		while (pix_y < 480) begin
			x = pix_x;
			y = pix_y;
			rgb = {vga_r, vga_g, vga_b};
			if (x < 640) begin
				if ((rgb == 3'b111) && (x >= 8) && (x < 633) && (y >= 8) && (y < 473)) begin
					if (y == 400) begin
						pad_lo = (x < pad_lo) ? x : pad_lo;
						pad_hi = (x > pad_hi) ? x : pad_hi;
					end else if ((y < 397) || (y > 403)) begin
						bx_lo = (x < bx_lo) ? x : bx_lo;
						bx_hi = (x > bx_hi) ? x : bx_hi;
						by_lo = (y < by_lo) ? y : by_lo;
						by_hi = (y > by_hi) ? y : by_hi;
					end
				end
				if (f == 0) begin
					exp_rgb = expected_rgb(x, y, pad_q[0], bx_q[0], by_q[0]);
					checks[B_FRAME]++;
					assert (rgb == exp_rgb) else begin
						errors[B_FRAME]++;
						$display("error at %0t ns: pixel %0d,%0d is %b, expected %b",
							$time, x, y, rgb, exp_rgb);
					end
				end
			end
			@(negedge clock);
		end
		got_pad = (pad_hi < 0) ? -1 : (pad_lo + pad_hi) / 2;
		got_bx = (bx_hi < 0) ? -1 : (bx_lo + bx_hi) / 2;
		got_by = (by_hi < 0) ? -1 : (by_lo + by_hi) / 2;
		compare_value(B_BALL, bx_hi - bx_lo + 1, 15, "ball width");
		compare_value(B_BALL, by_hi - by_lo + 1, 15, "ball height");
	endtask

	task automatic run_frames();
		int f;
		int b;
		int model_pad;
		int prev_bx;
		int prev_by;
		int total_checks;
		int total_errors;
		model_pad = 240;
		prev_bx = 0;
		prev_by = 0;
		for (f = 0; f < steps_q.size(); f++) begin
			capture_frame(f);
			$display("frame %0d: paddle %0d, ball %0d,%0d", f, got_pad, got_bx, got_by);
			if (f == 0) begin
				compare_value(B_FRAME, got_pad, pad_q[0], "first frame paddle");
				compare_value(B_FRAME, got_bx, bx_q[0], "first frame ball x");
				compare_value(B_FRAME, got_by, by_q[0], "first frame ball y");
				$display("%s: %0d checks, %0d errors", names[B_FRAME],
					checks[B_FRAME], errors[B_FRAME]);
			end else begin
				compare_value(B_BALL, (got_bx - prev_bx) ** 2, 1, "ball x step size");
				compare_value(B_BALL, (got_by - prev_by) ** 2, 1, "ball y step size");
			end
			compare_value(B_BALL, got_bx, bx_q[f], "ball x");
			compare_value(B_BALL, got_by, by_q[f], "ball y");
			compare_value(B_PAD, got_pad, pad_q[f], "paddle x");
			checks[B_PAD]++;
			assert (pad_q[f] == model_pad) else begin
				errors[B_PAD]++;
				$display("golden row %0d does not follow the paddle step and clamp rule", f);
			end
			// net steps of this frame show up in the next one
			model_pad = model_pad + steps_q[f];
			model_pad = (model_pad < 120) ? 120 : (model_pad > 520) ? 520 : model_pad;
			prev_bx = got_bx;
			prev_by = got_by;
			apply_steps(steps_q[f]);
		end
		monitor_on = 1'b0;
		total_checks = 0;
		total_errors = 0;
		for (b = 0; b < 5; b++) begin
			if (b != B_FRAME) begin
				$display("%s: %0d checks, %0d errors", names[b], checks[b], errors[b]);
			end
			total_checks += checks[b];
			total_errors += errors[b];
		end
		$display("total: %0d checks, %0d errors", total_checks, total_errors);
		if ((total_errors == 0) && (total_checks > 0)) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		quad_a = 1'b0;
		quad_b = 1'b0;
		phase = 0;
		cycle_count = 0;
		monitor_on = 1'b0;
		exp_x = 0;
		exp_y = 0;
		seed_init = $urandom(87111);
		read_golden();
		repeat (4) @(posedge clock);
		#10;
		reset = 1'b0;
		// outputs still hold their reset values here
		compare_value(B_SYNC, vga_hsync, 1, "hsync after reset");
		compare_value(B_SYNC, vga_vsync, 1, "vsync after reset");
		compare_value(B_BLANK, {vga_r, vga_g, vga_b}, 0, "colour after reset");
		@(posedge clock);
		monitor_on = 1'b1;
		if ((steps_q.size() == 0) || (steps_q.size() > MAX_FRAMES)) begin
			$display("pong_golden.txt holds %0d frames, 1 to %0d are needed",
				steps_q.size(), MAX_FRAMES);
			$display(">>> FAIL");
			$finish;
		end else begin
			run_frames();
		end
	end

endmodule
